// ==== source/loader_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types and constants for the housekeeping SPI program loader
// Base addresses are byte addresses seen by the core fetch unit
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package loader_pkg;

  // One instruction word, also the width of a boot address
  typedef logic [31:0] word_t;

  // SPI bits that make up one ICCM word, MSB first
  localparam int BITS_PER_WORD = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Boot targets
  ////////////////////////////////////////////////////////////////////////////

  // Held while power-on reset is asserted
  localparam word_t ROM_BASE  = 32'h0000_8000;
  // Program loaded over housekeeping SPI
  localparam word_t ICCM_BASE = 32'h1000_0000;
  // Execute in place from external flash
  localparam word_t QSPI_BASE = 32'h2000_0000;

  // Loader FSM states
  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    SHIFT = 2'b01,
    WRITE = 2'b10,
    DONE  = 2'b11
  } load_state_e;

endpackage

`default_nettype wire

// ==== source/iccm_prog_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Program write path into the ICCM, no handshake, one write per clock
// busy stays high for the whole open transfer and blocks fetches
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface iccm_prog_if #(
  parameter int ICCM_ADDR_W = 8
);
  import loader_pkg::*;

  logic                   we;
  logic [ICCM_ADDR_W-1:0] addr;
  word_t                  data;
  logic                   busy;

  // Loader side drives everything
  modport loader (output we, output addr, output data, output busy);

  // Memory side only listens
  modport mem (input we, input addr, input data, input busy);

endinterface

`default_nettype wire

// ==== source/hk_spi_frontend.sv ====
////////////////////////////////////////////////////////////////////////////
// SPI mode 0 slave front end, pins sampled in clk_i, strobes 3 cycles late
// SCK must stay high and low for at least 4 clk_i cycles each
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hk_spi_frontend (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               sck_i,
  input  logic               sdi_i,
  input  logic               csb_i,
  output logic               csb_fall_o,
  output logic               csb_rise_o,
  output logic               bit_strobe_o,
  output loader_pkg::word_t  shift_word_o
);
  import loader_pkg::*;

  // [0] and [1] synchronize, [2] is the previous value for edge detection
  logic [2:0] sck_q;
  logic [2:0] csb_q;
  logic [1:0] sdi_q;
  logic       sck_rise;
  word_t      shift_q;

  // Only shift while the host holds chip select low
  assign sck_rise = sck_q[1] & ~sck_q[2] & ~csb_q[1];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sck_q <= 3'b000;
      csb_q <= 3'b111;
      sdi_q <= 2'b00;
    end else begin
      sck_q <= {sck_q[1:0], sck_i};
      csb_q <= {csb_q[1:0], csb_i};
      sdi_q <= {sdi_q[0], sdi_i};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registered strobes
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bit_strobe_o <= 1'b0;
      csb_fall_o   <= 1'b0;
      csb_rise_o   <= 1'b0;
    end else begin
      bit_strobe_o <= sck_rise;
      csb_fall_o   <= ~csb_q[1] & csb_q[2];
      csb_rise_o   <= csb_q[1] & ~csb_q[2];
    end
  end

  // MSB first, new bit enters at the bottom
  always_ff @(posedge clk_i) begin
    if (sck_rise) begin
      shift_q <= {shift_q[$bits(word_t)-2:0], sdi_q[1]};
    end
  end

  assign shift_word_o = shift_q;

endmodule

`default_nettype wire

// ==== source/hk_load_counter.sv ====
////////////////////////////////////////////////////////////////////////////
// Bit and word-address counters for one SPI transfer
// Address wraps at the top of the ICCM, clear restarts at word 0
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hk_load_counter #(
  parameter int ICCM_ADDR_W = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   clear_i,
  input  logic                   bit_i,
  input  logic                   advance_i,
  output logic                   word_full_o,
  output logic                   any_word_o,
  output logic [ICCM_ADDR_W-1:0] word_addr_o
);
  import loader_pkg::*;

  localparam int CNT_W = $clog2(BITS_PER_WORD);

  logic [CNT_W-1:0]       bit_cnt_q;
  logic [ICCM_ADDR_W-1:0] addr_q;
  logic                   any_q;

  // Flags the bit that completes a word, in the same cycle it is counted
  assign word_full_o = bit_i && (bit_cnt_q == CNT_W'(BITS_PER_WORD - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      bit_cnt_q <= '0;
      addr_q    <= '0;
      any_q     <= 1'b0;
    end else begin
      if (bit_i) begin
        bit_cnt_q <= word_full_o ? '0 : bit_cnt_q + 1'b1;
      end
      if (advance_i) begin
        addr_q <= addr_q + 1'b1;
        any_q  <= 1'b1;
      end
    end
  end

  assign word_addr_o = addr_q;
  assign any_word_o  = any_q;

endmodule

`default_nettype wire

// ==== source/hk_load_fsm.sv ====
////////////////////////////////////////////////////////////////////////////
// Transfer FSM, one ICCM write per whole word, partial words are dropped
// Program-loaded flag holds from the close of a good transfer to the next
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hk_load_fsm #(
  parameter int ICCM_ADDR_W = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   csb_fall_i,
  input  logic                   csb_rise_i,
  input  logic                   bit_strobe_i,
  input  loader_pkg::word_t      shift_word_i,
  input  logic                   word_full_i,
  input  logic                   any_word_i,
  input  logic [ICCM_ADDR_W-1:0] word_addr_i,
  output logic                   clear_o,
  output logic                   count_o,
  output logic                   advance_o,
  iccm_prog_if.loader            prog,
  output logic                   prog_done_o
);
  import loader_pkg::*;

  load_state_e state_q;
  load_state_e state_d;
  word_t       wdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (csb_fall_i) state_d = SHIFT;
      SHIFT: begin
        if (csb_rise_i) begin
          state_d = any_word_i ? DONE : IDLE;
        end else if (bit_strobe_i && word_full_i) begin
          state_d = WRITE;
        end
      end
      // The word being written counts, so a close here still means done
      WRITE: state_d = csb_rise_i ? DONE : SHIFT;
      DONE: if (csb_fall_i) state_d = SHIFT;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the finished word for the write cycle
  always_ff @(posedge clk_i) begin
    if (state_q == SHIFT && bit_strobe_i && word_full_i) begin
      wdata_q <= shift_word_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Counter control and ICCM write port
  ////////////////////////////////////////////////////////////////////////////
  assign clear_o   = csb_fall_i && (state_q == IDLE || state_q == DONE);
  assign count_o   = bit_strobe_i && (state_q == SHIFT);
  assign advance_o = (state_q == WRITE);

  assign prog.we   = (state_q == WRITE);
  assign prog.addr = word_addr_i;
  assign prog.data = wdata_q;
  assign prog.busy = (state_q == SHIFT) || (state_q == WRITE);

  assign prog_done_o = (state_q == DONE);

endmodule

`default_nettype wire

// ==== source/iccm_ram.sv ====
////////////////////////////////////////////////////////////////////////////
// ICCM of 2**ICCM_ADDR_W words, contents are not reset
// Fetches are refused while a program transfer is open
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module iccm_ram #(
  parameter int ICCM_ADDR_W = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  iccm_prog_if.mem               prog,
  input  logic                   req_valid_i,
  input  logic [ICCM_ADDR_W-1:0] req_addr_i,
  output logic                   req_ready_o,
  output logic                   rsp_valid_o,
  output loader_pkg::word_t      rsp_data_o,
  input  logic                   rsp_ready_i
);
  import loader_pkg::*;

  localparam int DEPTH = 2 ** ICCM_ADDR_W;

  word_t mem [DEPTH];

  logic  rsp_valid_q;
  word_t rsp_data_q;
  logic  req_accept;

  // Program write port
  always_ff @(posedge clk_i) begin
    if (prog.we) begin
      mem[prog.addr] <= prog.data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Fetch port with a one-entry response slot
  ////////////////////////////////////////////////////////////////////////////

  // Take a new request if the slot is empty or drains this cycle
  assign req_ready_o = ~prog.busy & (~rsp_valid_q | rsp_ready_i);
  assign req_accept  = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Data held stable until the response is taken
  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      rsp_data_q <= mem[req_addr_i];
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_data_o  = rsp_data_q;

endmodule

`default_nettype wire

// ==== source/boot_addr_mngr.sv ====
////////////////////////////////////////////////////////////////////////////
// Boot address choice, ROM during power-on reset, then QSPI or ICCM
// boot_sel_i is taken as static and latched when por_n_i releases
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module boot_addr_mngr (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              por_n_i,
  input  logic              boot_sel_i,
  input  logic              prog_done_i,
  output loader_pkg::word_t boot_addr_o
);
  import loader_pkg::*;

  logic [1:0] por_q;
  logic       boot_sel_q;
  logic       prog_seen_q;
  word_t      boot_addr_q;
  word_t      boot_addr_d;

  always_comb begin
    if (!por_q[1]) boot_addr_d = ROM_BASE;
    else if (boot_sel_q) boot_addr_d = QSPI_BASE;
    else if (prog_done_i || prog_seen_q) boot_addr_d = ICCM_BASE;
    else boot_addr_d = ROM_BASE;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      por_q       <= 2'b00;
      boot_sel_q  <= 1'b0;
      prog_seen_q <= 1'b0;
      boot_addr_q <= ROM_BASE;
    end else begin
      por_q       <= {por_q[0], por_n_i};
      // Tracks the pin only while power-on reset is held
      if (!por_q[1]) boot_sel_q <= boot_sel_i;
      // Sticky once a program has been loaded
      prog_seen_q <= por_q[1] & (prog_seen_q | prog_done_i);
      boot_addr_q <= boot_addr_d;
    end
  end

  assign boot_addr_o = boot_addr_q;

endmodule

`default_nettype wire

// ==== source/azadi_loader_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Housekeeping SPI program loader with ICCM and boot address manager
// hk_sdo_o goes high once a transfer of at least one whole word closes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module azadi_loader_top #(
  parameter int ICCM_ADDR_W = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   por_n_i,
  input  logic                   boot_sel_i,
  // Housekeeping SPI
  input  logic                   hk_sck_i,
  input  logic                   hk_sdi_i,
  input  logic                   hk_csb_i,
  output logic                   hk_sdo_o,
  // Instruction fetch port
  input  logic                   fetch_req_valid_i,
  input  logic [ICCM_ADDR_W-1:0] fetch_req_addr_i,
  output logic                   fetch_req_ready_o,
  output logic                   fetch_rsp_valid_o,
  output loader_pkg::word_t      fetch_rsp_data_o,
  input  logic                   fetch_rsp_ready_i,
  output loader_pkg::word_t      boot_addr_o
);
  import loader_pkg::*;

  logic                   csb_fall;
  logic                   csb_rise;
  logic                   bit_strobe;
  word_t                  shift_word;
  logic                   cnt_clear;
  logic                   cnt_count;
  logic                   cnt_advance;
  logic                   word_full;
  logic                   any_word;
  logic [ICCM_ADDR_W-1:0] word_addr;

  iccm_prog_if #(.ICCM_ADDR_W(ICCM_ADDR_W)) u_iccm_prog ();

  ////////////////////////////////////////////////////////////////////////////
  // Loader
  ////////////////////////////////////////////////////////////////////////////
  hk_spi_frontend u_hk_spi_frontend (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .sck_i        ( hk_sck_i   ),
    .sdi_i        ( hk_sdi_i   ),
    .csb_i        ( hk_csb_i   ),
    .csb_fall_o   ( csb_fall   ),
    .csb_rise_o   ( csb_rise   ),
    .bit_strobe_o ( bit_strobe ),
    .shift_word_o ( shift_word )
  );

  hk_load_counter #(.ICCM_ADDR_W(ICCM_ADDR_W)) u_hk_load_counter (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .clear_i     ( cnt_clear   ),
    .bit_i       ( cnt_count   ),
    .advance_i   ( cnt_advance ),
    .word_full_o ( word_full   ),
    .any_word_o  ( any_word    ),
    .word_addr_o ( word_addr   )
  );

  hk_load_fsm #(.ICCM_ADDR_W(ICCM_ADDR_W)) u_hk_load_fsm (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .csb_fall_i   ( csb_fall    ),
    .csb_rise_i   ( csb_rise    ),
    .bit_strobe_i ( bit_strobe  ),
    .shift_word_i ( shift_word  ),
    .word_full_i  ( word_full   ),
    .any_word_i   ( any_word    ),
    .word_addr_i  ( word_addr   ),
    .clear_o      ( cnt_clear   ),
    .count_o      ( cnt_count   ),
    .advance_o    ( cnt_advance ),
    .prog         ( u_iccm_prog ),
    .prog_done_o  ( hk_sdo_o    )
  );

  // Instruction memory
  iccm_ram #(.ICCM_ADDR_W(ICCM_ADDR_W)) u_iccm_ram (
    .clk_i       ( clk_i             ),
    .rst_n_i     ( rst_n_i           ),
    .prog        ( u_iccm_prog       ),
    .req_valid_i ( fetch_req_valid_i ),
    .req_addr_i  ( fetch_req_addr_i  ),
    .req_ready_o ( fetch_req_ready_o ),
    .rsp_valid_o ( fetch_rsp_valid_o ),
    .rsp_data_o  ( fetch_rsp_data_o  ),
    .rsp_ready_i ( fetch_rsp_ready_i )
  );

  // Boot address selection
  boot_addr_mngr u_boot_addr_mngr (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .por_n_i     ( por_n_i     ),
    .boot_sel_i  ( boot_sel_i  ),
    .prog_done_i ( hk_sdo_o    ),
    .boot_addr_o ( boot_addr_o )
  );

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// Free-running clock, reset held low for RESET_CYCLES rising edges
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release a little after the edge, like every other input
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== bench/azadi_loader_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// Fetch handshake and program flag properties, bound into the loader top
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module azadi_loader_checker (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              csb_fall_i,
  input logic              csb_rise_i,
  input logic              fetch_req_valid_i,
  input logic              fetch_req_ready_i,
  input logic              fetch_rsp_valid_i,
  input logic              fetch_rsp_ready_i,
  input loader_pkg::word_t fetch_rsp_data_i,
  input logic              hk_sdo_i
);
  import loader_pkg::*;

  // Read by the testbench at the end of the run
  int unsigned assert_fails = 0;

  logic xfer_open_q;

  // Transfer window as seen from the chip select strobes
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      xfer_open_q <= 1'b0;
    end else if (csb_fall_i) begin
      xfer_open_q <= 1'b1;
    end else if (csb_rise_i) begin
      xfer_open_q <= 1'b0;
    end
  end

  // Stalled response keeps its slot and its data
  a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (fetch_rsp_valid_i && !fetch_rsp_ready_i) |=>
      (fetch_rsp_valid_i && $stable(fetch_rsp_data_i)))
  else begin
    $error("fetch response dropped or changed while stalled");
    assert_fails = assert_fails + 1;
  end

  a_no_fetch_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    xfer_open_q |-> !(fetch_req_valid_i && fetch_req_ready_i))
  else begin
    $error("fetch request accepted during a program transfer");
    assert_fails = assert_fails + 1;
  end

  a_sdo_low_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    xfer_open_q |-> !hk_sdo_i)
  else begin
    $error("program flag high while a transfer is open");
    assert_fails = assert_fails + 1;
  end

endmodule

`default_nettype wire

// ==== bench/azadi_loader_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Runs bench/loader_cases.txt from the project root, ICCM_ADDR_W fixed at 8
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module azadi_loader_tb;
  import loader_pkg::*;

  localparam int ICCM_ADDR_W = 8;
  localparam int SCK_PHASE   = 6;
  localparam int RST_CYCLES  = 16;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   por_n_i = 1'b0;
  logic                   boot_sel_i = 1'b0;
  logic                   hk_sck_i = 1'b0;
  logic                   hk_sdi_i = 1'b0;
  logic                   hk_csb_i = 1'b1;
  logic                   hk_sdo_o;
  logic                   fetch_req_valid_i = 1'b0;
  logic [ICCM_ADDR_W-1:0] fetch_req_addr_i = '0;
  logic                   fetch_req_ready_o;
  logic                   fetch_rsp_valid_o;
  word_t                  fetch_rsp_data_o;
  logic                   fetch_rsp_ready_i = 1'b0;
  word_t                  boot_addr_o;

  int unsigned word_errs = 0;
  int unsigned boot_errs = 0;
  int unsigned flag_errs = 0;
  int unsigned other_errs = 0;
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 0;
  logic [31:0] rng_state = 32'h3773_acfd;

  // Pending loads and reads taken from the cases file
  word_t                  load_words[$];
  logic [ICCM_ADDR_W-1:0] rd_addr[$];
  word_t                  rd_exp[$];
  int                     rd_case[$];

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(RST_CYCLES)) i_tb_clock_gen (
    .clk_o   ( clk_i   ),
    .rst_n_o ( rst_n_i )
  );

  azadi_loader_top #(.ICCM_ADDR_W(ICCM_ADDR_W)) i_azadi_loader_top (.*);

  bind azadi_loader_top azadi_loader_checker i_azadi_loader_checker (
    .clk_i             ( clk_i             ),
    .rst_n_i           ( rst_n_i           ),
    .csb_fall_i        ( csb_fall          ),
    .csb_rise_i        ( csb_rise          ),
    .fetch_req_valid_i ( fetch_req_valid_i ),
    .fetch_req_ready_i ( fetch_req_ready_o ),
    .fetch_rsp_valid_i ( fetch_rsp_valid_o ),
    .fetch_rsp_ready_i ( fetch_rsp_ready_i ),
    .fetch_rsp_data_i  ( fetch_rsp_data_o  ),
    .hk_sdo_i          ( hk_sdo_o          )
  );

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %08h actual %08h", name, exp, act);
      word_errs++;
    end
  endtask

  task automatic check_boot(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %08h actual %08h", name, exp, act);
      boot_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
      flag_errs++;
    end
  endtask

  // Leaves the caller just after a rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #2;
  endtask

  task automatic spi_bit(input logic b);
    hk_sdi_i = b;
    wait_cycles(SCK_PHASE);
    hk_sck_i = 1'b1;
    wait_cycles(SCK_PHASE);
    hk_sck_i = 1'b0;
  endtask

  // Whole words MSB first, then some random trailing bits
  task automatic spi_transfer(input int extra);
    logic [31:0] rnd;
    rnd = next_random();
    hk_csb_i = 1'b0;
    wait_cycles(SCK_PHASE);
    // Fetch attempts that the open transfer must hold off
    fetch_req_valid_i = 1'b1;
    foreach (load_words[i]) begin
      for (int b = BITS_PER_WORD - 1; b >= 0; b--) spi_bit(load_words[i][b]);
    end
    for (int b = 0; b < extra; b++) spi_bit(rnd[b]);
    wait_cycles(SCK_PHASE);
    fetch_req_valid_i = 1'b0;
    hk_csb_i = 1'b1;
    wait_cycles(2 * SCK_PHASE);
    load_words.delete();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Streamed fetches with random response stalls
  ////////////////////////////////////////////////////////////////////////////
  task automatic run_fetches();
    int n_req;
    int n_rsp;
    logic [31:0] rnd;
    n_req = 0;
    n_rsp = 0;
    while (n_rsp < rd_addr.size()) begin
      @(posedge clk_i);
      #2;
      rnd = next_random();
      fetch_req_valid_i = (n_req < rd_addr.size());
      fetch_req_addr_i  = (n_req < rd_addr.size()) ? rd_addr[n_req] : '0;
      fetch_rsp_ready_i = (rnd[1:0] != 2'b00);
      @(negedge clk_i);
      if (fetch_rsp_valid_o && fetch_rsp_ready_i) begin
        check_word($sformatf("case %0d read %0h", rd_case[n_rsp], rd_addr[n_rsp]),
                   rd_exp[n_rsp], fetch_rsp_data_o);
        n_rsp++;
      end
      if (fetch_req_valid_i && fetch_req_ready_o) n_req++;
    end
    wait_cycles(1);
    fetch_req_valid_i = 1'b0;
    fetch_rsp_ready_i = 1'b0;
    @(negedge clk_i);
    if (fetch_rsp_valid_o) begin
      $display("Fetch port returned a response that was never requested");
      other_errs++;
    end
    wait_cycles(1);
    rd_addr.delete();
    rd_exp.delete();
    rd_case.delete();
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, the cases did not complete", cycle_cnt);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    int fd;
    int ch;
    int n_lines;
    int case_no;
    int nwords;
    int extra;
    logic [7:0] op;
    logic por_v;
    logic sel_v;
    logic flag_v;
    word_t w_v;
    logic [ICCM_ADDR_W-1:0] a_v;
    int unsigned total;
    n_lines = 0;
    case_no = 0;
    fd = $fopen("bench/loader_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the cases file bench/loader_cases.txt");
      other_errs++;
    end else begin
      ch = $fgetc(fd);
      while (ch != -1) begin
        if (ch == 10) n_lines++;
        ch = $fgetc(fd);
      end
      $fclose(fd);
      cycle_limit = n_lines * 40 * 32 * 12 + RST_CYCLES;
      fd = $fopen("bench/loader_cases.txt", "r");
      wait (rst_n_i == 1'b1);
      wait_cycles(1);
      while ($fscanf(fd, " %c", op) == 1) begin
        case_no++;
        // Queued reads go out as one stream before any other operation
        if (op != "R" && rd_addr.size() != 0) run_fetches();
        case (op)
          "#": begin
            ch = $fgetc(fd);
            while (ch != 10 && ch != -1) ch = $fgetc(fd);
          end
          "P": begin
            void'($fscanf(fd, "%h %h", por_v, sel_v));
            por_n_i    = por_v;
            boot_sel_i = sel_v;
            wait_cycles(6);
          end
          "L": begin
            void'($fscanf(fd, "%d %d", nwords, extra));
            for (int i = 0; i < nwords; i++) begin
              void'($fscanf(fd, "%h", w_v));
              load_words.push_back(w_v);
            end
            spi_transfer(extra);
          end
          "R": begin
            void'($fscanf(fd, "%h %h", a_v, w_v));
            rd_addr.push_back(a_v);
            rd_exp.push_back(w_v);
            rd_case.push_back(case_no);
          end
          "B": begin
            void'($fscanf(fd, "%h", w_v));
            @(negedge clk_i);
            check_boot($sformatf("case %0d boot address", case_no), w_v, boot_addr_o);
            wait_cycles(1);
          end
          "D": begin
            void'($fscanf(fd, "%h", flag_v));
            @(negedge clk_i);
            check_flag($sformatf("case %0d program flag", case_no), flag_v, hk_sdo_o);
            wait_cycles(1);
          end
          default: begin
            $display("Unknown operation '%c' in case %0d of the cases file", op, case_no);
            other_errs++;
          end
        endcase
      end
      if (rd_addr.size() != 0) run_fetches();
      $fclose(fd);
    end
    other_errs += i_azadi_loader_top.i_azadi_loader_checker.assert_fails;
    total = word_errs + boot_errs + flag_errs + other_errs;
    $display("Errors: %0d total, %0d word, %0d boot, %0d flag, %0d other",
             total, word_errs, boot_errs, flag_errs, other_errs);
    if (total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/loader_cases.txt ====
# Ops: P por_n boot_sel | L nwords partial_bits word... | R addr word | B boot_addr | D flag
# L counts are decimal, every other number is hex
P 0 0
B 00008000
P 1 0
D 0
B 00008000
L 6 0 00000013 00100093 00200113 002081b3 deadbeef 01234567
D 1
B 10000000
R 0 00000013
R 1 00100093
R 2 00200113
R 3 002081b3
R 4 deadbeef
R 5 01234567
L 0 13
D 0
R 0 00000013
L 2 11 a5a5a5a5 5a5a5a5a
D 1
R 0 a5a5a5a5
R 1 5a5a5a5a
R 2 00200113
R 5 01234567
R 3 002081b3
P 0 1
B 00008000
P 1 1
B 20000000
L 0 5
D 0
P 0 0
P 1 0
B 00008000
L 1 0 cafef00d
D 1
B 10000000
R 0 cafef00d
R 1 5a5a5a5a

// ==== project.f ====
source/loader_pkg.sv
source/iccm_prog_if.sv
source/hk_spi_frontend.sv
source/hk_load_counter.sv
source/hk_load_fsm.sv
source/iccm_ram.sv
source/boot_addr_mngr.sv
source/azadi_loader_top.sv
bench/tb_clock_gen.sv
bench/azadi_loader_checker.sv
bench/azadi_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the loader testbench with Verilator and run it from the project root.
# The run passes only when the pass line appears in the simulation output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module azadi_loader_tb \
  -f project.f -Mdir obj_dir -o sim_loader || exit 1

out=$(./obj_dir/sim_loader +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "Everything OK" && exit 0 || exit 1
